// File: Makefile
TOP = tb_arcade_io

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f compile.f --top-module $(TOP)

sim:
	verilator --binary --timing -f compile.f --top-module $(TOP) -Mdir obj_dir -o sim_tb
	./obj_dir/sim_tb > sim.log 2>&1 || true
	cat sim.log
	grep -q "^TEST PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log

// File: compile.f
source/arcade_pkg.sv
source/download_if.sv
source/setup_registers.sv
source/input_mapper.sv
source/wave_ram.sv
source/wave_fetch.sv
source/arcade_io_top.sv
sim/tb_arcade_io.sv

// File: sim/tb_arcade_io.sv
`timescale 1ns/100ps

module tb_arcade_io
	import arcade_pkg::*;
();

	logic         clk_sys = 1'b0;
	logic         arst_n;
	logic         dn_download;
	dn_index_t    dn_index;
	logic         dn_wr;
	dn_addr_t     dn_addr;
	byte_t        dn_data;
	logic         reset_req;
	ctrl_t        ctrl1;
	ctrl_t        ctrl2;
	logic         start1;
	logic         start2;
	logic         coin1;
	logic         tilt;
	wave_addr_t   sample_addr;
	logic         sample_rd;
	logic         core_reset;
	game_id_t     game_mode;
	in_port_t     in_p1;
	in_port_t     in_p2;
	in_port_t     in_p3;
	in_port_t     in_p4;
	logic         coin;
	logic         dual_game_toggle;
	logic         sample_ack;
	byte_t        sample_data;

	// Stimulus side bookkeeping
	logic [31:0]  lfsr = 32'h7d27;
	byte_t        shadow [WAVE_WORDS * 2];
	int           tests = 0;
	int           wait_errors = 0;
	int           mark = 0;
	logic [31:0]  exp_ports;
	logic         exp_coin;
	logic         exp_toggle;
	game_id_t     exp_game;
	byte_t        exp_byte;
	logic         exp_core_reset;
	logic         exp_ack;
	int           port_req = 0;
	int           byte_req = 0;
	int           rst_req = 0;
	int           ack_req = 0;

	// Comparing side bookkeeping
	int           errors = 0;
	int           checks = 0;
	int           port_done = 0;
	int           byte_done = 0;
	int           rst_done = 0;
	int           ack_done = 0;

	arcade_io_top dut (.*);

	always #50 clk_sys = ~clk_sys;

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	// Expected ports for the kept games, packed p1 p2 p3 p4
	function automatic logic [31:0] expected_ports(input game_id_t g, input byte_t dip,
		input ctrl_t c1, input ctrl_t c2, input logic s1, input logic s2);
		ctrl_t      a;
		ctrl_t      b;
		logic       sim;
		logic [2:0] lives;
		in_port_t   p1;
		in_port_t   p2;
		in_port_t   p3;
		in_port_t   p4;
		sim = (g == GAME_HEIANKYO) && !dip[0];
		a = sim ? c1 : (c1 | c2);
		b = sim ? c2 : (c1 | c2);
		case (dip[2:1])
			2'd0:    lives = 3'd6;
			2'd1:    lives = 3'd5;
			2'd2:    lives = 3'd3;
			default: lives = 3'd7;
		endcase
		p1 = 8'hFF;
		p2 = 8'hFF;
		p3 = 8'hFF;
		p4 = 8'hFF;
		if (g == GAME_CARNIVAL)
		begin
			p1 = {3'b111, dip[0], 4'b1111};
			p2 = {2'b11, ~a[0], ~a[1], 4'b1011};
			p3 = {2'b11, ~a[4], ~s1, 4'b1111};
			p4 = {2'b11, ~s2, 5'b11111};
		end
		else if (g == GAME_DIGGER)
		begin
			p1 = {~a[3], ~a[1], ~a[2], ~a[0], ~a[5], ~a[4], ~s2, ~s1};
			p3 = {6'b111111, dip[1:0]};
		end
		else if (g == GAME_HEADON)
			p1 = {~a[3], ~a[1], ~a[2], ~a[0], ~a[4], dip[0], dip[2:1]};
		else if (g == GAME_HEIANKYO)
		begin
			p1 = {2'b11, ~a[4], ~a[3], dip[0], 1'b1, ~b[5], ~b[3]};
			p2 = {2'b11, ~a[5], ~a[0], 2'b01, ~b[5], ~b[0]};
			p3 = {3'b110, ~a[2], 3'b110, ~a[2]};
			p4 = {2'b11, ~s1, ~a[1], 1'b1, dip[1], ~s2, ~b[1]};
		end
		else if (g == GAME_SPACEATTACK)
		begin
			p1 = {~a[1], ~b[1], ~b[0], ~b[4], ~s2, ~s1, ~a[4], ~a[0]};
			p3 = {dip[4], 2'b11, dip[3], lives, dip[0]};
		end
		return {p1, p2, p3, p4};
	endfunction

	function automatic byte_t expected_sample(input wave_addr_t a);
		return shadow[a];
	endfunction

	task compare_port(input string name, input in_port_t got, input in_port_t exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("error %s: got %h expected %h", name, got, exp);
		end
	endtask

	task compare_byte(input string name, input byte_t got, input byte_t exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("error %s: got %h expected %h", name, got, exp);
		end
	endtask

	task compare_game(input string name, input game_id_t got, input game_id_t exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("error %s: got %h expected %h", name, got, exp);
		end
	endtask

	task compare_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("error %s: got %h expected %h", name, got, exp);
		end
	endtask

	// Checks run mid cycle, away from the drive point
	always @(negedge clk_sys)
	begin
		if (port_req != port_done)
		begin
			compare_port("in_p1", in_p1, exp_ports[31:24]);
			compare_port("in_p2", in_p2, exp_ports[23:16]);
			compare_port("in_p3", in_p3, exp_ports[15:8]);
			compare_port("in_p4", in_p4, exp_ports[7:0]);
			compare_bit("coin", coin, exp_coin);
			compare_bit("dual_game_toggle", dual_game_toggle, exp_toggle);
			compare_game("game_mode", game_mode, exp_game);
			port_done = port_req;
		end
		if (byte_req != byte_done)
		begin
			compare_byte("sample_data", sample_data, exp_byte);
			byte_done = byte_req;
		end
		if (rst_req != rst_done)
		begin
			compare_bit("core_reset", core_reset, exp_core_reset);
			rst_done = rst_req;
		end
		if (ack_req != ack_done)
		begin
			compare_bit("sample_ack", sample_ack, exp_ack);
			ack_done = ack_req;
		end
	end

	task step();
		@(posedge clk_sys);
		#10;
	endtask

	task abort_run(input string what);
		$display("timeout: %s", what);
		$display("TEST FAIL");
		$finish;
	endtask

	task end_test(input string name);
		int total;
		step();
		total = errors + wait_errors;
		tests++;
		$display("test %0d %s: %s", tests, name, (total == mark) ? "ok" : "failed");
		mark = total;
	endtask

	task load_byte(input dn_index_t idx, input dn_addr_t a, input byte_t d);
		dn_index = idx;
		dn_wr = 1'b1;
		dn_addr = a;
		dn_data = d;
		step();
		dn_wr = 1'b0;
	endtask

	task load_setup(input game_id_t g, input byte_t dip);
		dn_download = 1'b1;
		load_byte(DN_GAME, '0, {3'b000, g});
		load_byte(DN_DIP, '0, dip);
		dn_download = 1'b0;
		step();
		step();
	endtask

	task run_sets(input game_id_t g, input byte_t dip, input int count);
		logic [31:0] r;
		load_setup(g, dip);
		for (int i = 0; i < count; i++)
		begin
			r = take_bits(10);
			ctrl1 = r[9:0];
			r = take_bits(10);
			ctrl2 = r[9:0];
			r = take_bits(2);
			start1 = r[0];
			start2 = r[1];
			r = take_bits(2);
			coin1 = r[0];
			tilt = r[1];
			step();
			step();
			exp_ports = expected_ports(g, dip, ctrl1, ctrl2, start1, start2);
			exp_coin = coin1;
			exp_toggle = tilt;
			exp_game = g;
			port_req++;
		end
	endtask

	task toggle_read(input wave_addr_t a);
		sample_addr = a;
		sample_rd = ~sample_rd;
	endtask

	task wait_ack();
		int n;
		n = 0;
		while (sample_ack != sample_rd && n < 16)
		begin
			step();
			n++;
		end
		if (sample_ack != sample_rd)
			abort_run("sample_ack never answered the read request");
		else
		begin
			if (n != 2)
			begin
				wait_errors++;
				$display("sample_ack came %0d cycles after the request instead of 2", n);
			end
			exp_byte = expected_sample(sample_addr);
			byte_req++;
		end
	endtask

	initial
	begin
		logic [31:0] r;
		byte_t       dip;
		wave_addr_t  a6;
		logic        ack_before;
		int          n;

		arst_n = 1'b0;
		dn_download = 1'b0;
		dn_index = '0;
		dn_wr = 1'b0;
		dn_addr = '0;
		dn_data = '0;
		reset_req = 1'b0;
		ctrl1 = '0;
		ctrl2 = '0;
		start1 = 1'b0;
		start2 = 1'b0;
		coin1 = 1'b0;
		tilt = 1'b0;
		sample_addr = '0;
		sample_rd = 1'b0;
		repeat (16) @(posedge clk_sys);
		#10;
		arst_n = 1'b1;

		// Core reset around the ROM download and on request
		dn_download = 1'b1;
		for (int i = 0; i < 8; i++)
		begin
			load_byte(8'd0, dn_addr_t'(i), 8'hA5);
			exp_core_reset = 1'b1;
			rst_req++;
		end
		dn_download = 1'b0;
		n = 0;
		while (core_reset && n < 3)
		begin
			step();
			n++;
		end
		if (core_reset)
		begin
			wait_errors++;
			$display("core_reset still high 3 cycles after the download ended");
		end
		reset_req = 1'b1;
		step();
		exp_core_reset = 1'b1;
		rst_req++;
		reset_req = 1'b0;
		step();
		step();
		exp_core_reset = 1'b0;
		rst_req++;
		end_test("core reset");

		r = take_bits(8);
		run_sets(GAME_CARNIVAL, r[7:0], 40);
		r = take_bits(8);
		run_sets(GAME_DIGGER, r[7:0], 40);
		r = take_bits(8);
		run_sets(GAME_HEADON, r[7:0], 40);
		r = take_bits(8);
		run_sets(GAME_HEIANKYO, r[7:0], 40);
		r = take_bits(8);
		run_sets(GAME_SPACEATTACK, r[7:0], 40);
		end_test("game ports");

		// Heiankyo players apart, then shared
		r = take_bits(8);
		dip = r[7:0];
		dip[0] = 1'b0;
		run_sets(GAME_HEIANKYO, dip, 20);
		dip[0] = 1'b1;
		run_sets(GAME_HEIANKYO, dip, 20);
		end_test("heiankyo players");

		for (int v = 0; v < 4; v++)
		begin
			r = take_bits(8);
			dip = r[7:0];
			dip[2:1] = 2'(v);
			run_sets(GAME_SPACEATTACK, dip, 4);
		end
		run_sets(5'd31, 8'h00, 8);
		end_test("lives and unknown game");

		dn_download = 1'b1;
		for (int a = 0; a < WAVE_WORDS * 2; a++)
		begin
			r = take_bits(8);
			shadow[wave_addr_t'(a)] = r[7:0];
			load_byte(DN_WAVE, dn_addr_t'(a), r[7:0]);
		end
		dn_download = 1'b0;
		step();
		for (int i = 0; i < 32; i++)
		begin
			r = take_bits(11);
			toggle_read(r[10:0]);
			wait_ack();
		end
		end_test("wave reads");

		// Read held off by a wave download in progress
		r = take_bits(11);
		a6 = r[10:0];
		ack_before = sample_rd;
		dn_download = 1'b1;
		toggle_read(a6);
		for (int i = 0; i < 6; i++)
		begin
			r = take_bits(8);
			if (i == 3)
			begin
				shadow[a6] = r[7:0];
				load_byte(DN_WAVE, dn_addr_t'(a6), r[7:0]);
			end
			else
				load_byte(DN_WAVE, dn_addr_t'(a6 ^ 11'd64), shadow[a6 ^ 11'd64]);
			exp_ack = ack_before;
			ack_req++;
		end
		dn_download = 1'b0;
		wait_ack();
		end_test("read during download");

		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors + wait_errors);
		if (errors + wait_errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

// File: source/arcade_io_top.sv
`timescale 1ns/100ps

module arcade_io_top
	import arcade_pkg::*;
(
	input  logic       clk_sys,
	input  logic       arst_n,
	input  logic       dn_download,
	input  dn_index_t  dn_index,
	input  logic       dn_wr,
	input  dn_addr_t   dn_addr,
	input  byte_t      dn_data,
	input  logic       reset_req,
	input  ctrl_t      ctrl1,
	input  ctrl_t      ctrl2,
	input  logic       start1,
	input  logic       start2,
	input  logic       coin1,
	input  logic       tilt,
	input  wave_addr_t sample_addr,
	input  logic       sample_rd,
	output logic       core_reset,
	output game_id_t   game_mode,
	output in_port_t   in_p1,
	output in_port_t   in_p2,
	output in_port_t   in_p3,
	output in_port_t   in_p4,
	output logic       coin,
	output logic       dual_game_toggle,
	output logic       sample_ack,
	output byte_t      sample_data
);

	byte_t        dip0;
	logic         wave_busy;
	logic         rd_en;
	word_addr_t   rd_word;
	sample_word_t rd_data;

	download_if dn ();

	assign dn.download = dn_download;
	assign dn.index    = dn_index;
	assign dn.wr       = dn_wr;
	assign dn.addr     = dn_addr;
	assign dn.data     = dn_data;

	// Sample reads wait while wave data is being loaded
	assign wave_busy = dn_download && (dn_index == DN_WAVE);

	setup_registers u_setup (
		.clk_sys    (clk_sys),
		.arst_n     (arst_n),
		.dn         (dn),
		.reset_req  (reset_req),
		.core_reset (core_reset),
		.game_mode  (game_mode),
		.dip0       (dip0)
	);

	input_mapper u_inputs (
		.clk_sys          (clk_sys),
		.arst_n           (arst_n),
		.game_mode        (game_mode),
		.dip0             (dip0),
		.ctrl1            (ctrl1),
		.ctrl2            (ctrl2),
		.start1           (start1),
		.start2           (start2),
		.coin1            (coin1),
		.tilt             (tilt),
		.in_p1            (in_p1),
		.in_p2            (in_p2),
		.in_p3            (in_p3),
		.in_p4            (in_p4),
		.coin             (coin),
		.dual_game_toggle (dual_game_toggle)
	);

	wave_ram u_wave_ram (
		.clk_sys (clk_sys),
		.dn      (dn),
		.rd_en   (rd_en),
		.rd_word (rd_word),
		.rd_data (rd_data)
	);

	wave_fetch u_wave_fetch (
		.clk_sys     (clk_sys),
		.arst_n      (arst_n),
		.wave_busy   (wave_busy),
		.sample_addr (sample_addr),
		.sample_rd   (sample_rd),
		.rd_en       (rd_en),
		.rd_word     (rd_word),
		.rd_data     (rd_data),
		.sample_ack  (sample_ack),
		.sample_data (sample_data)
	);

endmodule

// File: source/arcade_pkg.sv
package arcade_pkg;

	// Game selector as loaded through download index 1
	typedef logic [4:0] game_id_t;

	localparam game_id_t GAME_CARNIVAL    = 5'd3;
	localparam game_id_t GAME_DIGGER      = 5'd4;
	localparam game_id_t GAME_HEADON      = 5'd6;
	localparam game_id_t GAME_HEIANKYO    = 5'd8;
	localparam game_id_t GAME_SPACEATTACK = 5'd16;

	// Loader stream
	typedef logic [7:0]  dn_index_t;
	typedef logic [24:0] dn_addr_t;

	localparam dn_index_t DN_GAME = 8'd1;
	localparam dn_index_t DN_WAVE = 8'd2;
	localparam dn_index_t DN_DIP  = 8'd254;

	// Download data, DIP bytes and sample bytes
	typedef logic [7:0] byte_t;

	// Active low input port as seen by the game core
	typedef logic [7:0] in_port_t;

	// Player controls
	// bit 0 right, 1 left, 2 down, 3 up, 4 to 9 fire1 to fire6
	typedef logic [9:0] ctrl_t;

	// Wave sample store
	localparam int WAVE_WORDS = 1024;

	typedef logic [10:0] wave_addr_t;
	typedef logic [9:0]  word_addr_t;
	typedef logic [15:0] sample_word_t;

	// Space Attack lives codes, indexed by DIP bits 2 to 1
	localparam logic [2:0] SA_LIVES_3 = 3'd6;
	localparam logic [2:0] SA_LIVES_4 = 3'd5;
	localparam logic [2:0] SA_LIVES_5 = 3'd3;
	localparam logic [2:0] SA_LIVES_6 = 3'd7;

endpackage

// File: source/download_if.sv
`timescale 1ns/100ps

interface download_if
	import arcade_pkg::*;
();
	logic      download;
	dn_index_t index;
	logic      wr;
	dn_addr_t  addr;
	byte_t     data;

	// Loader side
	modport source (
		output download,
		output index,
		output wr,
		output addr,
		output data
	);

	modport sink (
		input download,
		input index,
		input wr,
		input addr,
		input data
	);

endinterface

// File: source/input_mapper.sv
`timescale 1ns/100ps

module input_mapper
	import arcade_pkg::*;
(
	input  logic     clk_sys,
	input  logic     arst_n,
	input  game_id_t game_mode,
	input  byte_t    dip0,
	input  ctrl_t    ctrl1,
	input  ctrl_t    ctrl2,
	input  logic     start1,
	input  logic     start2,
	input  logic     coin1,
	input  logic     tilt,
	output in_port_t in_p1,
	output in_port_t in_p2,
	output in_port_t in_p3,
	output in_port_t in_p4,
	output logic     coin,
	output logic     dual_game_toggle
);

	logic       simultaneous;
	ctrl_t      joy;
	ctrl_t      p1;
	ctrl_t      p2;
	logic [2:0] sa_lives;

	logic p1_right;
	logic p1_left;
	logic p1_down;
	logic p1_up;
	logic p1_fire1;
	logic p1_fire2;
	logic p2_right;
	logic p2_left;
	logic p2_up;
	logic p2_fire1;
	logic p2_fire2;

	// Shared controls unless both players move on their own
	assign joy = ctrl1 | ctrl2;
	assign p1  = simultaneous ? ctrl1 : joy;
	assign p2  = simultaneous ? ctrl2 : joy;

	assign p1_right = p1[0];
	assign p1_left  = p1[1];
	assign p1_down  = p1[2];
	assign p1_up    = p1[3];
	assign p1_fire1 = p1[4];
	assign p1_fire2 = p1[5];
	assign p2_right = p2[0];
	assign p2_left  = p2[1];
	assign p2_up    = p2[3];
	assign p2_fire1 = p2[4];
	assign p2_fire2 = p2[5];

	always_comb
	begin
		case (dip0[2:1])
			2'd0:    sa_lives = SA_LIVES_3;
			2'd1:    sa_lives = SA_LIVES_4;
			2'd2:    sa_lives = SA_LIVES_5;
			default: sa_lives = SA_LIVES_6;
		endcase
	end

	always_ff @(posedge clk_sys or negedge arst_n)
	begin
		if (!arst_n)
		begin
			simultaneous     <= 1'b0;
			coin             <= 1'b0;
			dual_game_toggle <= 1'b0;
			in_p1            <= 8'hFF;
			in_p2            <= 8'hFF;
			in_p3            <= 8'hFF;
			in_p4            <= 8'hFF;
		end
		else
		begin
			coin             <= coin1;
			dual_game_toggle <= tilt;

			// Defaults, released ports read high
			simultaneous <= 1'b0;
			in_p1        <= 8'hFF;
			in_p2        <= 8'hFF;
			in_p3        <= 8'hFF;
			in_p4        <= 8'hFF;

			case (game_mode)
				GAME_CARNIVAL:
				begin
					in_p1 <= {3'b111, dip0[0], 4'b1111};
					in_p2 <= {2'b11, ~p1_right, ~p1_left, 4'b1011};
					in_p3 <= {2'b11, ~p1_fire1, ~start1, 4'b1111};
					in_p4 <= {2'b11, ~start2, 5'b11111};
				end
				GAME_DIGGER:
				begin
					in_p1 <= {~p1_up, ~p1_left, ~p1_down, ~p1_right,
						~p1_fire2, ~p1_fire1, ~start2, ~start1};
					in_p3 <= {6'b111111, dip0[1:0]};
				end
				GAME_HEADON:
				begin
					in_p1 <= {~p1_up, ~p1_left, ~p1_down, ~p1_right,
						~p1_fire1, dip0[0], dip0[2:1]};
				end
				GAME_HEIANKYO:
				begin
					in_p1 <= {2'b11, ~p1_fire1, ~p1_up, dip0[0], 1'b1, ~p2_fire2, ~p2_up};
					in_p2 <= {2'b11, ~p1_fire2, ~p1_right, 2'b01, ~p2_fire2, ~p2_right};
					in_p3 <= {3'b110, ~p1_down, 3'b110, ~p1_down};
					in_p4 <= {2'b11, ~start1, ~p1_left, 1'b1, dip0[1], ~start2, ~p2_left};
					// DIP bit 0 low selects two player simultaneous play
					simultaneous <= ~dip0[0];
				end
				GAME_SPACEATTACK:
				begin
					in_p1 <= {~p1_left, ~p2_left, ~p2_right, ~p2_fire1,
						~start2, ~start1, ~p1_fire1, ~p1_right};
					in_p3 <= {dip0[4], 2'b11, dip0[3], sa_lives, dip0[0]};
				end
				default:
				begin
					// Unknown games keep every port released
				end
			endcase
		end
	end

endmodule

// File: source/setup_registers.sv
`timescale 1ns/100ps

module setup_registers
	import arcade_pkg::*;
(
	input  logic            clk_sys,
	input  logic            arst_n,
	download_if.sink        dn,
	input  logic            reset_req,
	output logic            core_reset,
	output game_id_t        game_mode,
	output byte_t           dip0
);

	logic download_d;
	logic rom_loaded;
	logic game_wr;
	logic dip0_wr;

	assign game_wr = dn.wr && (dn.index == DN_GAME);
	assign dip0_wr = dn.wr && (dn.index == DN_DIP) && (dn.addr == '0);

	// Download end detection, sticky once seen
	always_ff @(posedge clk_sys or negedge arst_n)
	begin
		if (!arst_n)
		begin
			download_d <= 1'b0;
			rom_loaded <= 1'b0;
			core_reset <= 1'b1;
		end
		else
		begin
			download_d <= dn.download;
			if (download_d && !dn.download)
				rom_loaded <= 1'b1;
			// Core stays in reset until the ROM is in
			core_reset <= reset_req | ~rom_loaded;
		end
	end

	always_ff @(posedge clk_sys or negedge arst_n)
	begin
		if (!arst_n)
		begin
			game_mode <= '0;
			dip0      <= '0;
		end
		else
		begin
			if (game_wr)
				game_mode <= dn.data[4:0];
			if (dip0_wr)
				dip0 <= dn.data;
		end
	end

endmodule

// File: source/wave_fetch.sv
`timescale 1ns/100ps

module wave_fetch
	import arcade_pkg::*;
(
	input  logic         clk_sys,
	input  logic         arst_n,
	input  logic         wave_busy,
	input  wave_addr_t   sample_addr,
	input  logic         sample_rd,
	output logic         rd_en,
	output word_addr_t   rd_word,
	input  sample_word_t rd_data,
	output logic         sample_ack,
	output byte_t        sample_data
);

	logic served_rd;
	logic fetch_pend;
	logic lane_hi;

	// New request while the toggle differs from the last one served
	assign rd_en   = (sample_rd != served_rd) && !wave_busy && !fetch_pend;
	assign rd_word = sample_addr[10:1];

	always_ff @(posedge clk_sys or negedge arst_n)
	begin
		if (!arst_n)
		begin
			served_rd  <= 1'b0;
			fetch_pend <= 1'b0;
			sample_ack <= 1'b0;
		end
		else
		begin
			fetch_pend <= rd_en;
			if (rd_en)
				served_rd <= sample_rd;
			if (fetch_pend)
				sample_ack <= ~sample_ack;
		end
	end

	// Byte lane picked from the address held at issue
	always_ff @(posedge clk_sys)
	begin
		if (rd_en)
			lane_hi <= sample_addr[0];
		if (fetch_pend)
			sample_data <= lane_hi ? rd_data[15:8] : rd_data[7:0];
	end

endmodule

// File: source/wave_ram.sv
`timescale 1ns/100ps

module wave_ram
	import arcade_pkg::*;
(
	input  logic         clk_sys,
	download_if.sink     dn,
	input  logic         rd_en,
	input  word_addr_t   rd_word,
	output sample_word_t rd_data
);

	sample_word_t mem [WAVE_WORDS];

	logic       wave_wr;
	word_addr_t wr_word;

	assign wave_wr = dn.download && dn.wr && (dn.index == DN_WAVE);
	// Two bytes per word, even address in the low lane
	assign wr_word = dn.addr[10:1];

	always_ff @(posedge clk_sys)
	begin
		if (wave_wr && !dn.addr[0])
			mem[wr_word][7:0] <= dn.data;
		if (wave_wr && dn.addr[0])
			mem[wr_word][15:8] <= dn.data;
	end

	always_ff @(posedge clk_sys)
	begin
		if (rd_en)
			rd_data <= mem[rd_word];
	end

endmodule
